/* src/router_pkg.sv */
package router_pkg;

  localparam int DATA_W          = 8;
  localparam int NUM_PORTS       = 3;
  localparam int FIFO_DEPTH      = 16;
  localparam int FIFO_AW         = 4;
  localparam int SOFT_RST_CYCLES = 30; // Unread cycles before a port flush

  // Header byte as it arrives on the bus
  typedef struct packed {
    logic [5:0] len;
    logic [1:0] addr;
  } pkt_hdr_t;

  typedef struct packed {
    logic              lfd;  // Marks the header entry
    logic [DATA_W-1:0] data;
  } fifo_word_t;

  typedef enum logic [2:0] {
    DECODE_ADDRESS     = 3'b000,
    LOAD_FIRST_DATA    = 3'b001,
    LOAD_DATA          = 3'b010,
    WAIT_TILL_EMPTY    = 3'b011,
    CHECK_PARITY_ERROR = 3'b100,
    LOAD_PARITY        = 3'b101,
    FIFO_FULL_STATE    = 3'b110,
    LOAD_AFTER_FULL    = 3'b111
  } fsm_state_t;

endpackage

/* src/router_fsm.sv */
module router_fsm (
  input  logic       clk,
  input  logic       rst,
  input  logic       pkt_valid,
  input  logic [1:0] din,
  input  logic [2:0] fifo_empty,
  input  logic       sel_empty,
  input  logic       fifo_full,
  input  logic       soft_rst,
  input  logic       parity_done,
  input  logic       low_pkt_valid,
  output logic       wr_en_req,
  output logic       detect_addr,
  output logic       lfd_state,
  output logic       ld_state,
  output logic       laf_state,
  output logic       full_state,
  output logic       rst_int_reg,
  output logic       busy
);
  import router_pkg::*;

  fsm_state_t state;
  fsm_state_t state_nxt;

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= DECODE_ADDRESS;
    end else if (soft_rst) begin
      state <= DECODE_ADDRESS; // A flushed port drops the packet
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      DECODE_ADDRESS: begin
        // Destination 3 is ignored
        if (pkt_valid && din != 2'd3) begin
          state_nxt = fifo_empty[din] ? LOAD_FIRST_DATA : WAIT_TILL_EMPTY;
        end
      end
      LOAD_FIRST_DATA: begin
        state_nxt = LOAD_DATA;
      end
      LOAD_DATA: begin
        if (fifo_full) begin
          state_nxt = FIFO_FULL_STATE;
        end else if (!pkt_valid) begin
          state_nxt = LOAD_PARITY;
        end
      end
      WAIT_TILL_EMPTY: begin
        if (sel_empty) begin
          state_nxt = LOAD_FIRST_DATA;
        end
      end
      FIFO_FULL_STATE: begin
        if (!fifo_full) begin
          state_nxt = LOAD_AFTER_FULL;
        end
      end
      LOAD_AFTER_FULL: begin
        if (parity_done) begin
          state_nxt = CHECK_PARITY_ERROR; // Parity already in dout
        end else if (low_pkt_valid) begin
          state_nxt = LOAD_PARITY;
        end else begin
          state_nxt = LOAD_DATA;
        end
      end
      LOAD_PARITY: begin
        state_nxt = fifo_full ? FIFO_FULL_STATE : CHECK_PARITY_ERROR;
      end
      default: begin
        state_nxt = DECODE_ADDRESS;
      end
    endcase
  end

  assign detect_addr = (state == DECODE_ADDRESS);
  assign lfd_state   = (state == LOAD_FIRST_DATA);
  assign ld_state    = (state == LOAD_DATA);
  assign laf_state   = (state == LOAD_AFTER_FULL);
  assign full_state  = (state == FIFO_FULL_STATE);
  assign rst_int_reg = (state == CHECK_PARITY_ERROR);
  // Pending byte goes out only when the port has room
  assign wr_en_req   = (ld_state || laf_state || state == LOAD_PARITY) && !fifo_full;
  assign busy        = lfd_state || laf_state || full_state || rst_int_reg ||
                       state == LOAD_PARITY || state == WAIT_TILL_EMPTY;

  assert property (@(posedge clk) disable iff (!rst) !$isunknown(state));

  assert property (@(posedge clk) disable iff (!rst)
    !busy |-> state inside {DECODE_ADDRESS, LOAD_DATA});

endmodule

/* src/router_sync.sv */
module router_sync (
  input  logic       clk,
  input  logic       rst,
  input  logic       detect_addr,
  input  logic       pkt_valid,
  input  logic [1:0] data_in,
  input  logic       wr_en_req,
  input  logic [2:0] read_enb,
  input  logic [2:0] fifo_full,
  input  logic [2:0] fifo_empty,
  output logic [2:0] write_enb,
  output logic [2:0] soft_rst_port,
  output logic       sel_full,
  output logic       sel_empty,
  output logic       soft_rst
);
  import router_pkg::*;

  logic [1:0] addr;
  logic [4:0] idle_cnt [NUM_PORTS];

  always_ff @(posedge clk) begin
    if (!rst) begin
      addr <= 2'd0;
    end else if (detect_addr && pkt_valid) begin
      addr <= data_in;
    end
  end

  // Steering to the latched port
  always_comb begin
    write_enb = '0;
    sel_full  = 1'b0;
    sel_empty = 1'b1;
    if (addr != 2'd3) begin
      write_enb[addr] = wr_en_req;
      sel_full        = fifo_full[addr];
      sel_empty       = fifo_empty[addr];
    end
  end

  // Watchdog counts cycles with data waiting and no read
  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        idle_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (read_enb[i] || fifo_empty[i] || soft_rst_port[i]) begin
          idle_cnt[i] <= '0;
        end else begin
          idle_cnt[i] <= idle_cnt[i] + 5'd1;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      soft_rst_port[i] = (idle_cnt[i] == 5'(SOFT_RST_CYCLES));
    end
  end

  assign soft_rst = |soft_rst_port;

  assert property (@(posedge clk) disable iff (!rst) $onehot0(write_enb));

endmodule

/* src/router_reg.sv */
module router_reg (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   pkt_valid,
  input  logic [7:0]             data_in,
  input  logic                   fifo_full,
  input  logic                   detect_addr,
  input  logic                   ld_state,
  input  logic                   laf_state,
  input  logic                   full_state,
  input  logic                   lfd_state,
  input  logic                   rst_int_reg,
  output logic                   parity_done,
  output logic                   low_pkt_valid,
  output logic                   err,
  output router_pkg::fifo_word_t dout
);
  import router_pkg::*;

  pkt_hdr_t   hdr_in;
  pkt_hdr_t   hdr;
  logic       hdr_take;
  logic [7:0] full_hold;   // Byte that arrived on a full FIFO
  logic [7:0] int_parity;
  logic [7:0] pkt_parity;

  assign hdr_in   = data_in;
  assign hdr_take = detect_addr && pkt_valid;

  always_ff @(posedge clk) begin
    if (hdr_take) begin
      hdr <= hdr_in;
    end
    if (lfd_state) begin
      dout <= '{lfd: 1'b1, data: hdr};
    end else if (ld_state && !fifo_full) begin
      dout <= '{lfd: 1'b0, data: data_in};
    end else if (laf_state && !parity_done) begin
      dout <= '{lfd: 1'b0, data: full_hold}; // Replay
    end
    if (ld_state && fifo_full) begin
      full_hold <= data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_take) begin
      int_parity <= data_in;
    end else if (ld_state && pkt_valid) begin
      int_parity <= int_parity ^ data_in;
    end
    if (ld_state && !pkt_valid) begin
      pkt_parity <= data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      low_pkt_valid <= 1'b0;
      parity_done   <= 1'b0;
      err           <= 1'b0;
    end else begin
      if (detect_addr) begin
        low_pkt_valid <= 1'b0;
        parity_done   <= 1'b0;
      end else begin
        if (ld_state && !pkt_valid) begin
          low_pkt_valid <= 1'b1; // Parity byte taken
        end
        // Parity byte now sits in dout
        if ((ld_state && !pkt_valid && !fifo_full) || (laf_state && low_pkt_valid)) begin
          parity_done <= 1'b1;
        end
      end
      if (hdr_take && hdr_in.addr != 2'd3) begin
        err <= 1'b0;
      end else if (rst_int_reg) begin
        err <= (int_parity != pkt_parity);
      end
    end
  end

  // Pending byte survives the back-pressure wait
  assert property (@(posedge clk) disable iff (!rst)
    full_state |=> dout == $past(dout));

endmodule

/* src/router_fifo.sv */
module router_fifo (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   soft_rst,
  input  logic                   write_enb,
  input  logic                   read_enb,
  input  router_pkg::fifo_word_t data_in,
  output logic [7:0]             data_out,
  output logic                   empty,
  output logic                   full
);
  import router_pkg::*;

  fifo_word_t         mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               wr_open;  // Header stored since the last flush
  logic               push;
  logic               pop;

  assign empty = (count == '0);
  assign full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));

  // After a flush only a header may start new contents
  assign push = write_enb && !full && (data_in.lfd || wr_open);
  assign pop  = read_enb && !empty;

  assign data_out = mem[rd_ptr].data;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst || soft_rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      wr_open <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + FIFO_AW'(1);
      end
      if (push && data_in.lfd) begin
        wr_open <= 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + FIFO_AW'(1);
      end
      case ({push, pop})
        2'b10:   count <= count + (FIFO_AW + 1)'(1);
        2'b01:   count <= count - (FIFO_AW + 1)'(1);
        default: count <= count;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (!rst) write_enb |-> !full)
    else $error("write to a full FIFO");

  assert property (@(posedge clk) disable iff (!rst) read_enb |-> !empty)
    else $error("read from an empty FIFO");

endmodule

/* src/router_top.sv */
module router_top (
  input  logic       clk,
  input  logic       rst,
  input  logic       pkt_valid,
  input  logic [7:0] data_in,
  input  logic [2:0] read_enb,
  output logic [7:0] data_out_0,
  output logic [7:0] data_out_1,
  output logic [7:0] data_out_2,
  output logic [2:0] valid_out,
  output logic       busy,
  output logic       err
);
  import router_pkg::*;

  logic       detect_addr;
  logic       wr_en_req;
  logic       lfd_state;
  logic       ld_state;
  logic       laf_state;
  logic       full_state;
  logic       rst_int_reg;
  logic       sel_full;
  logic       sel_empty;
  logic       soft_rst;
  logic       parity_done;
  logic       low_pkt_valid;
  logic [2:0] fifo_full;
  logic [2:0] fifo_empty;
  logic [2:0] write_enb;
  logic [2:0] soft_rst_port;
  fifo_word_t dout;
  logic [7:0] fifo_data [NUM_PORTS];

  router_fsm fsm_inst (
    .clk           (clk),
    .rst           (rst),
    .pkt_valid     (pkt_valid),
    .din           (data_in[1:0]),
    .fifo_empty    (fifo_empty),
    .sel_empty     (sel_empty),
    .fifo_full     (sel_full),
    .soft_rst      (soft_rst),
    .parity_done   (parity_done),
    .low_pkt_valid (low_pkt_valid),
    .wr_en_req     (wr_en_req),
    .detect_addr   (detect_addr),
    .lfd_state     (lfd_state),
    .ld_state      (ld_state),
    .laf_state     (laf_state),
    .full_state    (full_state),
    .rst_int_reg   (rst_int_reg),
    .busy          (busy)
  );

  router_sync sync_inst (
    .clk           (clk),
    .rst           (rst),
    .detect_addr   (detect_addr),
    .pkt_valid     (pkt_valid),
    .data_in       (data_in[1:0]),
    .wr_en_req     (wr_en_req),
    .read_enb      (read_enb),
    .fifo_full     (fifo_full),
    .fifo_empty    (fifo_empty),
    .write_enb     (write_enb),
    .soft_rst_port (soft_rst_port),
    .sel_full      (sel_full),
    .sel_empty     (sel_empty),
    .soft_rst      (soft_rst)
  );

  router_reg reg_inst (
    .clk           (clk),
    .rst           (rst),
    .pkt_valid     (pkt_valid),
    .data_in       (data_in),
    .fifo_full     (sel_full),
    .detect_addr   (detect_addr),
    .ld_state      (ld_state),
    .laf_state     (laf_state),
    .full_state    (full_state),
    .lfd_state     (lfd_state),
    .rst_int_reg   (rst_int_reg),
    .parity_done   (parity_done),
    .low_pkt_valid (low_pkt_valid),
    .err           (err),
    .dout          (dout)
  );

  // One FIFO per output port, all fed from dout
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
    router_fifo fifo_inst (
      .clk       (clk),
      .rst       (rst),
      .soft_rst  (soft_rst_port[i]),
      .write_enb (write_enb[i]),
      .read_enb  (read_enb[i]),
      .data_in   (dout),
      .data_out  (fifo_data[i]),
      .empty     (fifo_empty[i]),
      .full      (fifo_full[i])
    );
  end

  assign valid_out  = ~fifo_empty;
  assign data_out_0 = fifo_data[0];
  assign data_out_1 = fifo_data[1];
  assign data_out_2 = fifo_data[2];

endmodule

/* testbench/router_clk_gen.sv */
module router_clk_gen (
  output logic clk
);

  // Free-running clock with a period of 4
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

endmodule

/* testbench/router_tb.sv */
module router_tb;
  import router_pkg::*;

  localparam int TIMEOUT = 200; // Cycles allowed for any single wait

  logic       clk;
  logic       rst;
  logic       pkt_valid;
  logic [7:0] data_in;
  logic [2:0] read_enb;
  logic [7:0] data_out_0;
  logic [7:0] data_out_1;
  logic [7:0] data_out_2;
  logic [2:0] valid_out;
  logic       busy;
  logic       err;

  int         seed = 22;
  string      test_name;
  logic [7:0] payload [64];
  logic [7:0] tx_q [$];       // Bytes as sent
  logic [7:0] rx_q [$];       // Bytes as popped from the ports
  logic [2:0] allowed_ports;
  int         check_req = 0;
  int         check_ack = 0;
  int         status_errors = 0;
  int         timeouts = 0;
  int         data_errors = 0;
  int         leak_errors = 0;

  router_clk_gen clk_gen_inst (.clk(clk));

  router_top router_top_inst (
    .clk        (clk),
    .rst        (rst),
    .pkt_valid  (pkt_valid),
    .data_in    (data_in),
    .read_enb   (read_enb),
    .data_out_0 (data_out_0),
    .data_out_1 (data_out_1),
    .data_out_2 (data_out_2),
    .valid_out  (valid_out),
    .busy       (busy),
    .err        (err)
  );

  // Parity byte: XOR of the header and every payload byte
  function automatic logic [7:0] packet_parity(input pkt_hdr_t hdr, input logic [7:0] pl [64],
                                               input int len);
    logic [7:0] acc;
    acc = hdr;
    for (int i = 0; i < len; i++) begin
      acc = acc ^ pl[i];
    end
    return acc;
  endfunction

  function automatic logic [7:0] port_data(input logic [1:0] port);
    case (port)
      2'd0:    return data_out_0;
      2'd1:    return data_out_1;
      default: return data_out_2;
    endcase
  endfunction

  // Byte is taken on the first rising edge that follows busy low
  task automatic drive_byte(input logic [7:0] b, input logic valid);
    int waited;
    begin
      @(negedge clk);
      data_in   = b;
      pkt_valid = valid;
      waited    = 0;
      while (busy && waited < TIMEOUT) begin
        @(negedge clk);
        waited++;
      end
      assert (!busy) else begin
        $display("Timeout in %s: busy stayed high while a byte was waiting", test_name);
        timeouts++;
      end
    end
  endtask

  task automatic send_packet(input logic [1:0] port, input int len, input logic bad_parity);
    pkt_hdr_t   hdr;
    logic [7:0] par;
    logic       exp_err;
    int         waited;
    begin
      hdr.len  = 6'(len);
      hdr.addr = port;
      for (int i = 0; i < len; i++) begin
        payload[i] = 8'($random(seed));
      end
      par = packet_parity(hdr, payload, len);
      if (bad_parity) begin
        par = par ^ 8'h5a;
      end
      exp_err = (par != packet_parity(hdr, payload, len));
      tx_q.push_back(hdr);
      drive_byte(hdr, 1'b1);
      for (int i = 0; i < len; i++) begin
        tx_q.push_back(payload[i]);
        drive_byte(payload[i], 1'b1);
      end
      tx_q.push_back(par);
      drive_byte(par, 1'b0);
      @(negedge clk);
      waited = 1;
      while (busy && waited < TIMEOUT) begin // Busy low again means back in decode
        @(negedge clk);
        waited++;
      end
      assert (!busy) else begin
        $display("Timeout in %s: router never returned to address decode", test_name);
        timeouts++;
      end
      assert (err == exp_err) else begin
        $display("** Error: %s err expected %0b actual %0b", test_name, exp_err, err);
        status_errors++;
      end
    end
  endtask

  task automatic read_bytes(input logic [1:0] port, input int count);
    int got;
    int idle;
    begin
      got  = 0;
      idle = 0;
      while (got < count && idle < TIMEOUT) begin
        @(negedge clk);
        if (valid_out[port]) begin
          read_enb[port] = 1'b1;
          rx_q.push_back(port_data(port));
          got++;
          idle = 0;
        end else begin
          read_enb[port] = 1'b0;
          idle++;
        end
      end
      @(negedge clk);
      read_enb[port] = 1'b0;
      assert (got == count) else begin
        $display("Timeout in %s: port %0d gave only %0d of %0d bytes", test_name, port, got,
                 count);
        timeouts++;
      end
    end
  endtask

  task automatic run_check;
    int waited;
    begin
      assert (valid_out == 3'b000) else begin
        $display("** Error: %s valid_out expected 000 actual %b", test_name, valid_out);
        status_errors++;
      end
      check_req++;
      waited = 0;
      while (check_ack != check_req && waited < TIMEOUT) begin
        @(negedge clk);
        waited++;
      end
      assert (check_ack == check_req) else begin
        $display("Timeout in %s: compare never completed", test_name);
        timeouts++;
      end
      tx_q.delete();
      rx_q.delete();
    end
  endtask

  // Compare received bytes with the sent packet stream
  always @(posedge clk) begin
    if (check_req != check_ack) begin
      assert (rx_q.size() == tx_q.size()) else begin
        $display("** Error: %s byte count expected %0d actual %0d", test_name, tx_q.size(),
                 rx_q.size());
        data_errors++;
      end
      for (int i = 0; i < tx_q.size() && i < rx_q.size(); i++) begin
        assert (rx_q[i] == tx_q[i]) else begin
          $display("** Error: %s byte %0d expected %02h actual %02h", test_name, i, tx_q[i],
                   rx_q[i]);
          data_errors++;
        end
      end
      check_ack <= check_req;
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      assert ((valid_out & ~allowed_ports) == 3'b000) else begin
        $display("Data showed up on a port that no packet addressed, valid_out %b in %s",
                 valid_out, test_name);
        leak_errors++;
      end
    end
  end

  initial begin
    int waited;
    rst           = 1'b0;
    pkt_valid     = 1'b0;
    data_in       = 8'h00;
    read_enb      = 3'b000;
    allowed_ports = 3'b000;
    test_name     = "reset";
    repeat (2) @(posedge clk);
    @(negedge clk);
    // Idle router after reset
    assert (!busy && !err && valid_out == 3'b000) else begin
      $display("** Error: %s busy/err/valid_out expected 0/0/000 actual %b/%b/%b", test_name,
               busy, err, valid_out);
      status_errors++;
    end
    rst = 1'b1;

    for (int p = 0; p < NUM_PORTS; p++) begin
      test_name     = $sformatf("port_%0d", p);
      allowed_ports = 3'b001 << p;
      fork
        send_packet(2'(p), 3 + 2 * p, 1'b0);
        read_bytes(2'(p), 5 + 2 * p);
      join
      run_check();
    end

    test_name     = "dest_3";
    allowed_ports = 3'b000;
    @(negedge clk);
    data_in   = 8'h17; // Length 5, destination 3
    pkt_valid = 1'b1;
    @(negedge clk);
    pkt_valid = 1'b0;
    repeat (10) begin
      @(negedge clk);
      assert (!busy) else begin
        $display("** Error: %s busy expected 0 actual 1", test_name);
        status_errors++;
      end
    end
    run_check();

    // Late reader lets port 1 fill up
    test_name     = "full_path";
    allowed_ports = 3'b010;
    fork
      send_packet(2'd1, 40, 1'b0);
      begin
        repeat (20) @(negedge clk);
        read_bytes(2'd1, 42);
      end
    join
    run_check();

    test_name     = "bad_parity";
    allowed_ports = 3'b100;
    fork
      send_packet(2'd2, 6, 1'b1);
      read_bytes(2'd2, 8);
    join
    run_check();
    test_name = "err_clear";
    fork
      send_packet(2'd2, 4, 1'b0);
      read_bytes(2'd2, 6);
    join
    run_check();

    test_name = "wait_empty";
    send_packet(2'd2, 4, 1'b0);
    fork
      send_packet(2'd2, 6, 1'b0);
      begin
        repeat (2) @(negedge clk);
        repeat (8) begin
          @(negedge clk);
          assert (busy) else begin
            $display("** Error: %s busy expected 1 actual 0", test_name);
            status_errors++;
          end
        end
        read_bytes(2'd2, 14);
      end
    join
    run_check();

    test_name     = "soft_reset";
    allowed_ports = 3'b001;
    send_packet(2'd0, 5, 1'b0);
    waited = 0;
    while (valid_out[0] && waited < 40) begin
      @(negedge clk);
      waited++;
    end
    assert (!valid_out[0]) else begin
      $display("Port 0 still held its unread packet after %0d cycles", waited);
      status_errors++;
    end
    tx_q.delete(); // Flushed packet is gone
    test_name = "after_flush";
    fork
      send_packet(2'd0, 7, 1'b0);
      read_bytes(2'd0, 9);
    join
    run_check();

    $display("Errors: %0d data, %0d status, %0d port leak, %0d timeout", data_errors,
             status_errors, leak_errors, timeouts);
    if (data_errors + status_errors + leak_errors + timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* router_top.f */
src/router_pkg.sv
src/router_fsm.sv
src/router_sync.sv
src/router_reg.sv
src/router_fifo.sv
src/router_top.sv
testbench/router_clk_gen.sv
testbench/router_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -j 0 --top-module router_tb -f router_top.f \
  && ./obj_dir/Vrouter_tb | tee /dev/stderr | grep -q "Simulation finished: PASS" \
  && echo "Run passed" \
  || { echo "Run failed"; exit 1; }
